// File: rtl/ps2_frame_pkg.sv
package ps2_frame_pkg;

  localparam int DATA_BITS = 8;
  localparam int FRAME_BITS = 11; // start, data, parity, stop

  // parity bit that leaves an odd number of ones across data and parity
  function automatic logic odd_parity(input logic [DATA_BITS-1:0] data);
    return ~(^data);
  endfunction

  typedef enum logic [3:0] {
    idle,
    rx_clk_low,
    rx_clk_high,
    rx_sample,
    rx_finish,
    tx_inhibit,
    tx_request,
    tx_wait_first_fall,
    tx_shift,
    tx_wait_rise,
    tx_release,
    tx_wait_ack,
    tx_ack_done
  } ps2_state_t;

endpackage

// File: rtl/ps2_timing_pkg.sv
package ps2_timing_pkg;

  // equal consecutive clock samples needed before a level counts as stable
  localparam int FILTER_DEPTH = 5;

  // all waits in system clock cycles, figured for a 12 MHz clock
  localparam int DEFAULT_INHIBIT_CYCLES = 1200; // 100 us
  localparam int DEFAULT_REQUEST_CYCLES = 240;  // 20 us
  localparam int DEFAULT_SETTLE_CYCLES = 63;

endpackage

// File: rtl/ps2_line_filter.sv
`timescale 1ns/1ps

module ps2_line_filter
  import ps2_timing_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic ps2_clk_in,
  input  logic ps2_data_in,
  output logic clk_high,
  output logic clk_low,
  output logic data_sync
);

  logic [1:0] clk_meta;
  logic [1:0] data_meta;
  logic [FILTER_DEPTH-1:0] clk_history;

  // both lines idle high, so reset loads ones everywhere
  always_ff @(posedge clk) begin
    if (rst) begin
      clk_meta <= 2'b11;
      data_meta <= 2'b11;
      clk_history <= '1;
    end else begin
      clk_meta <= {clk_meta[0], ps2_clk_in};
      data_meta <= {data_meta[0], ps2_data_in};
      clk_history <= {clk_history[FILTER_DEPTH-2:0], clk_meta[1]};
    end
  end

  // a level is stable only once the whole history agrees on it
  assign clk_high = &clk_history;
  assign clk_low = ~|clk_history;

  assign data_sync = data_meta[1]; // data is steady while the clock is low

endmodule

// File: rtl/ps2_delay.sv
`timescale 1ns/1ps

module ps2_delay #(
  parameter int duration = 1
) (
  input  logic clk,
  input  logic rst,
  input  logic enable,
  output logic done
);

  localparam int width = (duration > 0) ? $clog2(duration + 1) : 1;

  logic [width-1:0] count;

  assign done = (count == width'(duration));

  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      count <= '0;
    end else if (!done) begin
      count <= count + 1'b1; // saturates at duration
    end
  end

endmodule

// File: rtl/ps2_host_fsm.sv
`timescale 1ns/1ps

module ps2_host_fsm
  import ps2_frame_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clk_high,
  input  logic                 clk_low,
  input  logic                 data_sync,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] tx_data,
  input  logic                 inhibit_done,
  input  logic                 request_done,
  input  logic                 settle_done,
  output logic                 ps2_clk_drive_low,
  output logic                 ps2_data_drive_low,
  output logic                 inhibit_enable,
  output logic                 request_enable,
  output logic                 settle_enable,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_error,
  output logic                 tx_ack,
  output logic                 tx_nack,
  output logic                 ready
);

  localparam int count_bits = $clog2(FRAME_BITS + 1);

  ps2_state_t state;
  logic [count_bits-1:0] bit_count;
  logic [FRAME_BITS-1:0] rx_frame;
  logic [FRAME_BITS-2:0] tx_bits; // data LSB first, then parity and stop
  logic ack_seen;
  logic frame_good;

  // rx_frame[0] is the start bit once all eleven bits have been shifted in
  assign frame_good = !rx_frame[0] && rx_frame[FRAME_BITS-1]
                      && (rx_frame[FRAME_BITS-2] == odd_parity(rx_frame[DATA_BITS:1]));

  assign ready = (state == idle);
  assign inhibit_enable = (state == tx_inhibit);
  assign request_enable = (state == tx_request);
  assign settle_enable = (state == tx_wait_first_fall);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      bit_count <= '0;
      ps2_clk_drive_low <= 1'b0;
      ps2_data_drive_low <= 1'b0;
      rx_valid <= 1'b0;
      rx_error <= 1'b0;
      tx_ack <= 1'b0;
      tx_nack <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      rx_error <= 1'b0;
      tx_ack <= 1'b0;
      tx_nack <= 1'b0;

      case (state)
        idle: begin
          bit_count <= '0;
          if (clk_low) begin // device clocking wins over a request
            state <= rx_sample;
          end else if (tx_start) begin
            ps2_clk_drive_low <= 1'b1;
            state <= tx_inhibit;
          end
        end

        rx_sample: begin
          bit_count <= bit_count + 1'b1;
          state <= rx_clk_low;
        end

        rx_clk_low: begin
          if (clk_high) begin
            state <= (bit_count == count_bits'(FRAME_BITS)) ? rx_finish : rx_clk_high;
          end
        end

        rx_clk_high: begin
          if (clk_low) begin
            state <= rx_sample;
          end
        end

        rx_finish: begin
          rx_valid <= frame_good;
          rx_error <= !frame_good;
          state <= idle;
        end

        tx_inhibit: begin
          if (inhibit_done) begin
            ps2_data_drive_low <= 1'b1; // start bit
            state <= tx_request;
          end
        end

        tx_request: begin
          if (request_done) begin
            ps2_clk_drive_low <= 1'b0; // hand the clock back to the device
            state <= tx_wait_first_fall;
          end
        end

        // the released clock needs time to read high through the filter
        tx_wait_first_fall: begin
          if (settle_done && clk_low) begin
            state <= tx_shift;
          end
        end

        tx_shift: begin
          if (clk_low) begin
            ps2_data_drive_low <= !tx_bits[0];
            bit_count <= bit_count + 1'b1;
            state <= tx_wait_rise;
          end
        end

        tx_wait_rise: begin
          if (clk_high) begin
            if (bit_count == count_bits'(FRAME_BITS - 1)) begin
              state <= tx_release;
            end else begin
              state <= tx_shift;
            end
          end
        end

        tx_release: begin
          ps2_data_drive_low <= 1'b0; // the device owns data for the acknowledge
          state <= tx_wait_ack;
        end

        tx_wait_ack: begin
          if (clk_low) begin
            state <= tx_ack_done;
          end
        end

        tx_ack_done: begin
          if (clk_high) begin
            tx_ack <= ack_seen;
            tx_nack <= !ack_seen;
            state <= idle;
          end
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // receive frame, transmit shift register and the acknowledge sample
  always_ff @(posedge clk) begin
    if (state == rx_sample) begin
      rx_frame <= {data_sync, rx_frame[FRAME_BITS-1:1]}; // first bit ends up at bit 0
    end
    if (state == rx_finish && frame_good) begin
      rx_data <= rx_frame[DATA_BITS:1];
    end
    if (state == idle) begin
      tx_bits <= {1'b1, odd_parity(tx_data), tx_data};
    end else if (state == tx_shift && clk_low) begin
      tx_bits <= {1'b1, tx_bits[FRAME_BITS-2:1]};
    end
    if (state == tx_wait_ack && clk_low) begin
      ack_seen <= !data_sync; // the device pulls data low to acknowledge
    end
  end

endmodule

// File: rtl/ps2_host.sv
`timescale 1ns/1ps

module ps2_host
  import ps2_frame_pkg::*, ps2_timing_pkg::*;
#(
  parameter int inhibit_cycles = DEFAULT_INHIBIT_CYCLES,
  parameter int request_cycles = DEFAULT_REQUEST_CYCLES,
  parameter int settle_cycles = DEFAULT_SETTLE_CYCLES
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ps2_clk_in,
  input  logic                 ps2_data_in,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] tx_data,
  output logic                 ps2_clk_drive_low,
  output logic                 ps2_data_drive_low,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_error,
  output logic                 tx_ack,
  output logic                 tx_nack,
  output logic                 ready
);

  logic clk_high;
  logic clk_low;
  logic data_sync;
  logic inhibit_enable;
  logic inhibit_done;
  logic request_enable;
  logic request_done;
  logic settle_enable;
  logic settle_done;

  ps2_line_filter line_filter (
    .clk        (clk),
    .rst        (rst),
    .ps2_clk_in (ps2_clk_in),
    .ps2_data_in(ps2_data_in),
    .clk_high   (clk_high),
    .clk_low    (clk_low),
    .data_sync  (data_sync)
  );

  // clock held low before the request
  ps2_delay #(.duration(inhibit_cycles)) inhibit_delay (
    .clk   (clk),
    .rst   (rst),
    .enable(inhibit_enable),
    .done  (inhibit_done)
  );

  ps2_delay #(.duration(request_cycles)) request_delay (
    .clk   (clk),
    .rst   (rst),
    .enable(request_enable),
    .done  (request_done)
  );

  ps2_delay #(.duration(settle_cycles)) settle_delay (
    .clk   (clk),
    .rst   (rst),
    .enable(settle_enable),
    .done  (settle_done)
  );

  ps2_host_fsm fsm (
    .clk               (clk),
    .rst               (rst),
    .clk_high          (clk_high),
    .clk_low           (clk_low),
    .data_sync         (data_sync),
    .tx_start          (tx_start),
    .tx_data           (tx_data),
    .inhibit_done      (inhibit_done),
    .request_done      (request_done),
    .settle_done       (settle_done),
    .ps2_clk_drive_low (ps2_clk_drive_low),
    .ps2_data_drive_low(ps2_data_drive_low),
    .inhibit_enable    (inhibit_enable),
    .request_enable    (request_enable),
    .settle_enable     (settle_enable),
    .rx_data           (rx_data),
    .rx_valid          (rx_valid),
    .rx_error          (rx_error),
    .tx_ack            (tx_ack),
    .tx_nack           (tx_nack),
    .ready             (ready)
  );

endmodule

// File: test/ps2_device_model.sv
`timescale 1ns/1ps

module ps2_device_model
  import ps2_frame_pkg::*;
#(
  parameter int half_period = 40
) (
  input  logic                 clk,
  input  logic                 ps2_clk,
  input  logic                 ps2_data,
  input  logic                 withhold_ack,
  output logic                 clk_low,
  output logic                 data_low,
  output logic [DATA_BITS-1:0] got_data,
  output logic                 got_parity,
  output logic                 got_stop,
  output int                   request_count,
  output logic                 model_error
);

  logic send_clk_low = 1'b0;
  logic send_data_low = 1'b0;
  logic resp_clk_low = 1'b0;
  logic resp_data_low = 1'b0;

  assign clk_low = send_clk_low | resp_clk_low;
  assign data_low = send_data_low | resp_data_low;

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // data changes in the middle of the high phase, the host samples while low
  task automatic send_frame(input logic [DATA_BITS-1:0] value, input logic bad_parity);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, (~(^value)) ^ bad_parity, value, 1'b0};
    @(posedge clk);
    for (int i = 0; i < FRAME_BITS; i++) begin
      send_data_low <= !frame[i];
      wait_cycles(half_period / 2);
      send_clk_low <= 1'b1;
      wait_cycles(half_period);
      send_clk_low <= 1'b0;
      wait_cycles(half_period / 2);
    end
    send_data_low <= 1'b0;
  endtask

  task automatic receive_host_frame();
    logic [FRAME_BITS-2:0] bits;
    bits = '0;
    request_count <= request_count + 1;
    wait_cycles(half_period);
    for (int i = 0; i < FRAME_BITS - 1; i++) begin
      resp_clk_low <= 1'b1;
      wait_cycles(half_period);
      bits[i] = ps2_data; // read just before the rising edge
      resp_clk_low <= 1'b0;
      wait_cycles(half_period);
    end
    got_data <= bits[DATA_BITS-1:0];
    got_parity <= bits[DATA_BITS];
    got_stop <= bits[DATA_BITS+1];
    wait_cycles(half_period / 2);
    resp_data_low <= !withhold_ack;
    wait_cycles(half_period / 2);
    resp_clk_low <= 1'b1; // acknowledge clock
    wait_cycles(half_period);
    resp_clk_low <= 1'b0;
    wait_cycles(half_period / 2);
    resp_data_low <= 1'b0;
    wait_cycles(half_period / 2);
  endtask

  initial begin
    got_data = '0;
    got_parity = 1'b0;
    got_stop = 1'b0;
    request_count = 0;
    model_error = 1'b0;
  end

  // a clock held low by the host followed by data low is a request to send
  always begin : monitor
    logic saw_request;
    int n;
    @(posedge clk);
    if (!ps2_clk && !clk_low) begin
      saw_request = 1'b0;
      n = 0;
      while (!ps2_clk && n < 10000) begin
        if (!ps2_data) saw_request = 1'b1;
        n++;
        @(posedge clk);
      end
      if (n >= 10000) begin
        model_error <= 1'b1;
        $display("device model: host held the clock line low for too long");
      end else if (saw_request) begin
        receive_host_frame();
      end
    end
  end

endmodule

// File: test/ps2_host_properties.sv
`timescale 1ns/1ps

module ps2_host_properties
  import ps2_frame_pkg::*;
#(
  parameter int inhibit_cycles = 60
) (
  input logic       clk,
  input logic       rst,
  input ps2_state_t state,
  input logic       ready,
  input logic       ps2_clk_drive_low,
  input logic       ps2_data_drive_low,
  input logic       rx_valid,
  input logic       rx_error,
  input logic       tx_ack,
  input logic       tx_nack
);

  int clk_drive_cycles; // how long the host has held the clock low so far

  always @(posedge clk) begin
    if (rst || !ps2_clk_drive_low) clk_drive_cycles <= 0;
    else clk_drive_cycles <= clk_drive_cycles + 1;
  end

  assert property (@(posedge clk) disable iff (rst)
    ready |-> (!ps2_clk_drive_low && !ps2_data_drive_low))
    else $error("host drives a line while idle");

  assert property (@(posedge clk) disable iff (rst)
    (state == rx_clk_low || state == rx_clk_high || state == rx_sample || state == rx_finish)
    |-> (!ps2_clk_drive_low && !ps2_data_drive_low))
    else $error("host drives a line while receiving");

  assert property (@(posedge clk) disable iff (rst) !(rx_valid && rx_error))
    else $error("rx_valid and rx_error high together");

  assert property (@(posedge clk) disable iff (rst)
    ($rose(ps2_data_drive_low) && state == tx_request) |-> clk_drive_cycles >= inhibit_cycles)
    else $error("data pulled low before the inhibit time ran out");

  assert property (@(posedge clk) disable iff (rst)
    (tx_ack || tx_nack) |-> $past(state) == tx_ack_done)
    else $error("acknowledge pulse outside the acknowledge state");

endmodule

bind ps2_host_fsm ps2_host_properties #(.inhibit_cycles(60)) host_props (
  .clk               (clk),
  .rst               (rst),
  .state             (state),
  .ready             (ready),
  .ps2_clk_drive_low (ps2_clk_drive_low),
  .ps2_data_drive_low(ps2_data_drive_low),
  .rx_valid          (rx_valid),
  .rx_error          (rx_error),
  .tx_ack            (tx_ack),
  .tx_nack           (tx_nack)
);

// File: test/tb_ps2_host.sv
`timescale 1ns/1ps

module tb_ps2_host
  import ps2_frame_pkg::*, ps2_timing_pkg::*;
;

  localparam int inhibit_cycles = 60;
  localparam int request_cycles = 20;
  localparam int settle_cycles = 8;
  localparam int device_half_period = 8 * FILTER_DEPTH; // far above filter plus sync delay

  logic clk;
  logic rst;
  logic tx_start;
  logic [DATA_BITS-1:0] tx_data;
  logic withhold_ack;
  logic ps2_clk;
  logic ps2_data;
  logic host_clk_low, host_data_low, dev_clk_low, dev_data_low;
  logic [DATA_BITS-1:0] rx_data, got_data, last_good, value;
  logic rx_valid, rx_error, tx_ack, tx_nack, ready;
  logic got_parity, got_stop, model_error;
  int request_count;
  int rx_valid_count = 0;
  int rx_error_count = 0;
  int ack_count = 0;
  int nack_count = 0;
  int checks = 0;
  int failures = 0;
  int tests = 0;
  int valid_before, error_before, ack_before, nack_before, requests_before;
  logic [31:0] seed = 32'h03de_53d0;

  // open-drain lines: low when either side pulls
  assign ps2_clk = !(host_clk_low || dev_clk_low);
  assign ps2_data = !(host_data_low || dev_data_low);

  ps2_host #(
    .inhibit_cycles(inhibit_cycles),
    .request_cycles(request_cycles),
    .settle_cycles (settle_cycles)
  ) UUT (
    .clk(clk), .rst(rst), .ps2_clk_in(ps2_clk), .ps2_data_in(ps2_data),
    .tx_start(tx_start), .tx_data(tx_data),
    .ps2_clk_drive_low(host_clk_low), .ps2_data_drive_low(host_data_low),
    .rx_data(rx_data), .rx_valid(rx_valid), .rx_error(rx_error),
    .tx_ack(tx_ack), .tx_nack(tx_nack), .ready(ready)
  );

  ps2_device_model #(.half_period(device_half_period)) device (
    .clk(clk), .ps2_clk(ps2_clk), .ps2_data(ps2_data), .withhold_ack(withhold_ack),
    .clk_low(dev_clk_low), .data_low(dev_data_low),
    .got_data(got_data), .got_parity(got_parity), .got_stop(got_stop),
    .request_count(request_count), .model_error(model_error)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rx_valid) rx_valid_count <= rx_valid_count + 1;
    if (rx_error) rx_error_count <= rx_error_count + 1;
    if (tx_ack) ack_count <= ack_count + 1;
    if (tx_nack) nack_count <= nack_count + 1;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (expected == actual) else begin
      $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      failures++;
    end
  endtask

  task automatic wait_for_rx_result();
    int n;
    n = 0;
    while (rx_valid_count == valid_before && rx_error_count == error_before && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (n >= 200) begin
      $display("timeout: no receive result after the frame was sent");
      failures++;
    end
  endtask

  task automatic wait_for_tx_result();
    int n;
    n = 0;
    while (ack_count == ack_before && nack_count == nack_before && n < 4000) begin
      @(posedge clk);
      n++;
    end
    if (n >= 4000) begin
      $display("timeout: transmission never ended with tx_ack or tx_nack");
      failures++;
    end
  endtask

  task automatic wait_until_busy();
    int n;
    n = 0;
    while (ready && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (n >= 200) begin
      $display("timeout: host never left idle during the incoming frame");
      failures++;
    end
  endtask

  task automatic pulse_tx_start(input logic [DATA_BITS-1:0] b);
    @(posedge clk);
    tx_data <= b;
    tx_start <= 1'b1;
    @(posedge clk);
    tx_start <= 1'b0;
  endtask

  task automatic snapshot_counts();
    valid_before = rx_valid_count;
    error_before = rx_error_count;
    ack_before = ack_count;
    nack_before = nack_count;
    requests_before = request_count;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s done, failures so far %0d", tests, name, failures);
  endtask

  initial begin
    rst = 1'b1;
    tx_start = 1'b0;
    tx_data = '0;
    withhold_ack = 1'b0;
    last_good = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("ready", 1, 32'(ready));
    check_value("ps2_clk_drive_low", 0, 32'(host_clk_low));
    check_value("ps2_data_drive_low", 0, 32'(host_data_low));
    check_value("pulses", 0, 32'({rx_valid, rx_error, tx_ack, tx_nack}));
    finish_test("reset");

    for (int i = 0; i < 8; i++) begin
      seed = next_random(seed);
      value = seed[23:16];
      snapshot_counts();
      device.send_frame(value, 1'b0);
      wait_for_rx_result();
      repeat (20) @(posedge clk);
      @(negedge clk);
      check_value("rx_valid pulses", 1, rx_valid_count - valid_before);
      check_value("rx_error pulses", 0, rx_error_count - error_before);
      check_value("rx_data", 32'(value), 32'(rx_data));
      last_good = value;
    end
    finish_test("receive");

    seed = next_random(seed);
    snapshot_counts();
    device.send_frame(seed[23:16], 1'b1);
    wait_for_rx_result();
    repeat (20) @(posedge clk);
    @(negedge clk);
    check_value("rx_error pulses", 1, rx_error_count - error_before);
    check_value("rx_valid pulses", 0, rx_valid_count - valid_before);
    check_value("rx_data", 32'(last_good), 32'(rx_data));
    finish_test("parity error");

    for (int i = 0; i < 4; i++) begin
      seed = next_random(seed);
      value = seed[23:16];
      snapshot_counts();
      pulse_tx_start(value);
      wait_for_tx_result();
      @(negedge clk);
      check_value("ready", 1, 32'(ready));
      check_value("tx_ack pulses", 1, ack_count - ack_before);
      check_value("tx_nack pulses", 0, nack_count - nack_before);
      check_value("device requests", 1, request_count - requests_before);
      check_value("device data", 32'(value), 32'(got_data));
      check_value("device parity", 32'(~^value), 32'(got_parity));
      check_value("device stop", 1, 32'(got_stop));
      repeat (2 * device_half_period) @(posedge clk); // let the device finish its ack
    end
    finish_test("transmit with acknowledge");

    withhold_ack <= 1'b1;
    seed = next_random(seed);
    snapshot_counts();
    pulse_tx_start(seed[23:16]);
    wait_for_tx_result();
    repeat (2 * device_half_period) @(posedge clk);
    @(negedge clk);
    check_value("tx_nack pulses", 1, nack_count - nack_before);
    check_value("tx_ack pulses", 0, ack_count - ack_before);
    withhold_ack <= 1'b0;
    finish_test("transmit without acknowledge");

    seed = next_random(seed);
    value = seed[23:16];
    snapshot_counts();
    fork
      device.send_frame(value, 1'b0);
      begin
        wait_until_busy();
        pulse_tx_start(~value);
      end
    join
    wait_for_rx_result();
    repeat (4 * device_half_period) @(posedge clk);
    @(negedge clk);
    check_value("rx_valid pulses", 1, rx_valid_count - valid_before);
    check_value("rx_data", 32'(value), 32'(rx_data));
    check_value("device requests", 0, request_count - requests_before);
    check_value("tx pulses", 0, (ack_count - ack_before) + (nack_count - nack_before));
    check_value("model_error", 0, 32'(model_error));
    finish_test("busy strobe ignored");

    $display("tests %0d, checks %0d, failures %0d", tests, checks, failures);
    if (failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: files.f
rtl/ps2_frame_pkg.sv
rtl/ps2_timing_pkg.sv
rtl/ps2_line_filter.sv
rtl/ps2_delay.sv
rtl/ps2_host_fsm.sv
rtl/ps2_host.sv
test/ps2_device_model.sv
test/ps2_host_properties.sv
test/tb_ps2_host.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ps2_host \
  -f files.f \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
